// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP = attn_tb
FILELIST = attn_top.f
OBJ_DIR = obj_dir
PASS_MSG = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== attn_top.f ====
verilog/attn_num_pkg.sv
verilog/attn_ctrl_pkg.sv
verilog/attn_loader.sv
verilog/attn_ctrl.sv
verilog/attn_projection.sv
verilog/attn_score.sv
verilog/attn_output.sv
verilog/attn_top.sv
test/attn_tb.sv

// ==== test/attn_tb.sv ====
// Testbench for the attention engine
// Tests come from test/attn_tests.txt; each loads a tile with idle gaps,
// sends stray strobes while busy, and checks every output against a
// reference model, plus output spacing and zero data while idle

`timescale 1ns/1ps

module attn_tb;
	import attn_num_pkg::*;
	import attn_ctrl_pkg::*;

	localparam int DIM = 8;
	localparam int MAX_TESTS = 32;
	localparam int TEST_CYCLES = 5 * DIM * DIM + 100;

	logic clk;
	logic rst_n;
	logic in_valid;
	rows_t t_in;
	elem_t in_data;
	elem_t w_q;
	elem_t w_k;
	elem_t w_v;
	logic out_valid;
	out_t out_data;

	// Test table, one entry per data line
	logic [127:0] test_name [MAX_TESTS];
	logic [63:0] test_mode [MAX_TESTS];
	int test_rows [MAX_TESTS];
	int test_fill [MAX_TESTS];
	longint test_ref00 [MAX_TESTS];
	int n_tests;
	logic tests_read;
	int errors;
	int failed_tests;
	int seed;

	elem_t x [DIM][DIM];
	elem_t wq [DIM][DIM];
	elem_t wk [DIM][DIM];
	elem_t wv [DIM][DIM];
	longint expected [DIM][DIM];

	attn_top #(.DIM(DIM)) dut (
		.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .T(t_in), .in_data(in_data),
		.w_q(w_q), .w_k(w_k), .w_v(w_v), .out_valid(out_valid), .out_data(out_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic read_tests();
		int fd;
		int cnt;
		string line;
		n_tests = 0;
		fd = $fopen("test/attn_tests.txt", "r");
		if (fd == 0) begin
			$display("Cannot open test/attn_tests.txt");
			errors++;
		end else begin
			while (!$feof(fd) && n_tests < MAX_TESTS) begin
				if ($fgets(line, fd) == 0)
					break;
				if (line.len() > 1 && line[0] != "#") begin
					cnt = $sscanf(line, "%s %d %s %d %d", test_name[n_tests],
						test_rows[n_tests], test_mode[n_tests], test_fill[n_tests],
						test_ref00[n_tests]);
					if (cnt == 5) begin
						n_tests++;
					end else begin
						$display("Malformed line in test file: %0s", line);
						errors++;
					end
				end
			end
			$fclose(fd);
		end
		if (n_tests == 0) begin
			$display("No tests were read from the test file");
			errors++;
		end
		tests_read = 1'b1;
	endtask

	task automatic fill_tile(input logic [63:0] mode, input int f);
		for (int r = 0; r < DIM; r++) begin
			for (int c = 0; c < DIM; c++) begin
				case (mode)
					"ident": begin
						x[r][c] = (r == c) ? elem_t'(1) : elem_t'(0);
						wq[r][c] = (r == c) ? elem_t'(f) : elem_t'(0);
						wk[r][c] = wq[r][c];
						wv[r][c] = wq[r][c];
					end
					"rand": begin
						x[r][c] = elem_t'($random(seed));
						wq[r][c] = elem_t'($random(seed));
						wk[r][c] = elem_t'($random(seed));
						wv[r][c] = elem_t'($random(seed));
					end
					default: begin
						// Negated K weights make every score clamp
						x[r][c] = elem_t'(f);
						wq[r][c] = elem_t'(f);
						wk[r][c] = (mode == "neg") ? elem_t'(-f) : elem_t'(f);
						wv[r][c] = elem_t'(f);
					end
				endcase
			end
		end
	endtask

	// X rows at or past T count as zero
	task automatic build_model(input int t);
		longint q [DIM][DIM];
		longint k [DIM][DIM];
		longint v [DIM][DIM];
		longint s [DIM][DIM];
		for (int r = 0; r < DIM; r++) begin
			for (int c = 0; c < DIM; c++) begin
				q[r][c] = 0;
				k[r][c] = 0;
				v[r][c] = 0;
				for (int i = 0; i < DIM; i++) begin
					if (r < t) begin
						q[r][c] += longint'(x[r][i]) * longint'(wq[i][c]);
						k[r][c] += longint'(x[r][i]) * longint'(wk[i][c]);
						v[r][c] += longint'(x[r][i]) * longint'(wv[i][c]);
					end
				end
			end
		end
		for (int r = 0; r < DIM; r++) begin
			for (int c = 0; c < DIM; c++) begin
				s[r][c] = 0;
				for (int i = 0; i < DIM; i++)
					s[r][c] += q[r][i] * k[c][i];
				if (s[r][c] < 0)
					s[r][c] = 0;
				else
					s[r][c] = s[r][c] / 3;
			end
		end
		for (int r = 0; r < DIM; r++) begin
			for (int c = 0; c < DIM; c++) begin
				expected[r][c] = 0;
				for (int i = 0; i < DIM; i++)
					expected[r][c] += s[r][i] * v[i][c];
			end
		end
	endtask

	task automatic load_tile(input int t);
		for (int i = 0; i < DIM * DIM; i++) begin
			@(posedge clk);
			if (i % 8 == 5) begin
				in_valid <= 1'b0;
				@(posedge clk);
			end
			in_valid <= 1'b1;
			t_in <= rows_t'(t);
			in_data <= x[i / DIM][i % DIM];
			w_q <= wq[i / DIM][i % DIM];
			w_k <= wk[i / DIM][i % DIM];
			w_v <= wv[i / DIM][i % DIM];
		end
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	// Strobes while the engine is busy must be ignored
	task automatic send_stray(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			in_valid <= 1'b1;
			t_in <= rows_t'(i);
			in_data <= elem_t'($random(seed));
			w_q <= elem_t'($random(seed));
			w_k <= elem_t'($random(seed));
			w_v <= elem_t'($random(seed));
		end
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	task automatic check_outputs(input int ti);
		int t;
		t = test_rows[ti];
		@(negedge clk);
		while (!out_valid)
			@(negedge clk);
		for (int i = 0; i < t * DIM; i++) begin
			if (i > 0)
				@(negedge clk);
			assert (out_valid) else begin
				$display("Test %0s: out_valid dropped after %0d outputs", test_name[ti], i);
				errors++;
			end
			assert (out_data == expected[i / DIM][i % DIM]) else begin
				$display("Fail %0s (%0d,%0d): expected %0d, actual %0d", test_name[ti],
					i / DIM, i % DIM, expected[i / DIM][i % DIM], out_data);
				errors++;
			end
		end
		@(negedge clk);
		assert (!out_valid) else begin
			$display("Test %0s: more than %0d outputs arrived", test_name[ti], t * DIM);
			errors++;
		end
	endtask

	task automatic run_test(input int ti);
		int err_before;
		err_before = errors;
		fill_tile(test_mode[ti], test_fill[ti]);
		build_model(test_rows[ti]);
		if (test_mode[ti] != "rand") begin
			assert (expected[0][0] == test_ref00[ti]) else begin
				$display("Fail %0s model (0,0): expected %0d, actual %0d", test_name[ti],
					test_ref00[ti], expected[0][0]);
				errors++;
			end
		end
		load_tile(test_rows[ti]);
		send_stray(16);
		check_outputs(ti);
		if (errors == err_before) begin
			$display("Test %0s: passed, %0d outputs", test_name[ti], test_rows[ti] * DIM);
		end else begin
			$display("Test %0s: failed, %0d errors", test_name[ti], errors - err_before);
			failed_tests++;
		end
	endtask

	always @(negedge clk) begin
		if (!out_valid) begin
			assert (out_data == '0) else begin
				$display("out_data is nonzero while out_valid is low at %0t", $time);
				errors++;
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		t_in = '0;
		in_data = '0;
		w_q = '0;
		w_k = '0;
		w_v = '0;
		errors = 0;
		failed_tests = 0;
		seed = 32'hfa6b;
		tests_read = 1'b0;
		read_tests();
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		for (int ti = 0; ti < n_tests; ti++)
			run_test(ti);
		$display("%0d tests, %0d passed, %0d failed, %0d errors", n_tests,
			n_tests - failed_tests, failed_tests, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial begin
		wait (tests_read);
		repeat (n_tests * TEST_CYCLES + 10) @(posedge clk);
		$display("Timeout: tests did not finish within %0d cycles", n_tests * TEST_CYCLES + 10);
		$display("Finished with errors");
		$finish;
	end

endmodule

// ==== test/attn_tests.txt ====
# name  T  fill_mode  fill_value  expected_out(0,0)
# expected_out(0,0) is not checked for rand
ident_t8  8 ident  3  9
const_t4  4 const  2  349440
neg_t8    8 neg    5  0
rand_t1   1 rand   0  0
ident_t4  4 ident -4  -20
const_t1  1 const  1  1360
rand_t4   4 rand   0  0
const_t8  8 const -3  7962624

// ==== verilog/attn_ctrl.sv ====
// Phase controller
// IDLE/LOAD/PROJ/SCORE/OUT state machine with the shared step,
// column and row counters, output issue count and drain counter

`timescale 1ns/1ps

module attn_ctrl #(
	parameter int DIM = attn_num_pkg::MAX_DIM
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     load_done,
	input  attn_ctrl_pkg::rows_t     rows,
	output logic                     accept,
	output logic                     proj_en,
	output attn_ctrl_pkg::mat_sel_t  mat_sel,
	output logic                     score_en,
	output logic                     out_issue,
	output attn_ctrl_pkg::idx_t      step,
	output attn_ctrl_pkg::idx_t      col,
	output attn_ctrl_pkg::idx_t      row
);
	import attn_ctrl_pkg::*;

	localparam int CNT_W = $clog2(DIM * DIM + 1);
	localparam idx_t LAST = idx_t'(DIM - 1);

	phase_t phase;
	phase_t phase_nxt;
	logic [CNT_W-1:0] issue_cnt;
	logic [CNT_W-1:0] issue_total;
	logic [$clog2(OUT_LAT + 1)-1:0] drain_cnt;
	logic step_wrap;
	logic col_wrap;

	assign issue_total = CNT_W'(rows) * CNT_W'(DIM);
	assign step_wrap = step == LAST;
	assign col_wrap = col == LAST;

	assign accept = (phase == IDLE || phase == LOAD) && !load_done;
	assign proj_en = phase == PROJ;
	assign score_en = phase == SCORE;
	assign out_issue = (phase == OUT) && (issue_cnt != issue_total);

	always_comb begin
		phase_nxt = phase;
		case (phase)
			IDLE: phase_nxt = LOAD;
			LOAD: if (load_done) phase_nxt = PROJ;
			PROJ: if (mat_sel == MAT_V && col_wrap && step_wrap) phase_nxt = SCORE;
			SCORE: if (row == LAST && step_wrap) phase_nxt = OUT;
			OUT: if (!out_issue && drain_cnt == OUT_LAT - 1) phase_nxt = IDLE;
			default: phase_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			phase <= IDLE;
		else
			phase <= phase_nxt;
	end

	// Counters wrap to zero at the end of each phase
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			step <= '0;
			col <= '0;
			row <= '0;
			mat_sel <= MAT_Q;
			issue_cnt <= '0;
			drain_cnt <= '0;
		end else begin
			case (phase)
				PROJ: begin
					step <= step_wrap ? '0 : step + 1'b1;
					if (step_wrap) begin
						col <= col_wrap ? '0 : col + 1'b1;
						if (col_wrap) begin
							case (mat_sel)
								MAT_Q: mat_sel <= MAT_K;
								MAT_K: mat_sel <= MAT_V;
								default: mat_sel <= MAT_Q;
							endcase
						end
					end
				end
				SCORE: begin
					step <= step_wrap ? '0 : step + 1'b1;
					if (step_wrap)
						row <= (row == LAST) ? '0 : row + 1'b1;
				end
				OUT: begin
					if (out_issue) begin
						col <= col_wrap ? '0 : col + 1'b1;
						if (col_wrap)
							row <= row + 1'b1;
						issue_cnt <= issue_cnt + 1'b1;
					end else begin
						drain_cnt <= drain_cnt + 1'b1;
					end
				end
				default: begin
					step <= '0;
					col <= '0;
					row <= '0;
					mat_sel <= MAT_Q;
					issue_cnt <= '0;
					drain_cnt <= '0;
				end
			endcase
		end
	end

endmodule

// ==== verilog/attn_ctrl_pkg.sv ====
// Sequencing package for the attention engine
// Phase and projection-matrix enums, index and row-count types,
// output pipeline latency

package attn_ctrl_pkg;

	typedef enum logic [2:0] {IDLE, LOAD, PROJ, SCORE, OUT} phase_t;

	typedef enum logic [1:0] {MAT_Q, MAT_K, MAT_V} mat_sel_t;

	typedef logic [2:0] idx_t;
	typedef logic [3:0] rows_t;

	// Product stage plus adder stage
	localparam int OUT_LAT = 2;

endpackage

// ==== verilog/attn_loader.sv ====
// Input loader
// Writes X and the three weight matrices in row-major order,
// one element of each per strobe, and latches T on the first strobe

`timescale 1ns/1ps

module attn_loader #(
	parameter int DIM = attn_num_pkg::MAX_DIM
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_valid,
	input  attn_ctrl_pkg::rows_t t_in,
	input  attn_num_pkg::elem_t  in_data,
	input  attn_num_pkg::elem_t  w_q,
	input  attn_num_pkg::elem_t  w_k,
	input  attn_num_pkg::elem_t  w_v,
	input  logic                 accept,
	output attn_num_pkg::elem_t  x_mat [DIM][DIM],
	output attn_num_pkg::elem_t  wq_mat [DIM][DIM],
	output attn_num_pkg::elem_t  wk_mat [DIM][DIM],
	output attn_num_pkg::elem_t  wv_mat [DIM][DIM],
	output attn_ctrl_pkg::rows_t rows,
	output logic                 load_done
);
	import attn_ctrl_pkg::*;

	localparam idx_t LAST = idx_t'(DIM - 1);

	idx_t ld_row;
	idx_t ld_col;
	logic strobe;
	logic first;
	rows_t cur_t;

	assign strobe = in_valid && accept;
	assign first = (ld_row == '0) && (ld_col == '0);
	// T is not latched yet on the first strobe
	assign cur_t = first ? t_in : rows;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ld_row <= '0;
			ld_col <= '0;
			rows <= '0;
			load_done <= 1'b0;
		end else begin
			load_done <= strobe && (ld_row == LAST) && (ld_col == LAST);
			if (strobe) begin
				ld_col <= (ld_col == LAST) ? '0 : ld_col + 1'b1;
				if (ld_col == LAST)
					ld_row <= (ld_row == LAST) ? '0 : ld_row + 1'b1;
				if (first)
					rows <= t_in;
			end
		end
	end

	// Rows of X past T are zero so the full-length sums stay exact
	always_ff @(posedge clk) begin
		if (strobe) begin
			x_mat[ld_row][ld_col] <= (rows_t'(ld_row) < cur_t) ? in_data : '0;
			wq_mat[ld_row][ld_col] <= w_q;
			wk_mat[ld_row][ld_col] <= w_k;
			wv_mat[ld_row][ld_col] <= w_v;
		end
	end

endmodule

// ==== verilog/attn_num_pkg.sv ====
// Numeric package for the attention datapath
// Element widths are derived from the largest tile edge
// elem_t  input and weight element
// proj_t  element of Q, K and V
// score_t raw and scaled score
// prod_t, out_t  output pipeline terms

package attn_num_pkg;

	localparam int MAX_DIM = 8;

	localparam int ELEM_W = 8;
	localparam int PROJ_W = 2 * ELEM_W + $clog2(MAX_DIM);
	localparam int SCORE_W = 2 * PROJ_W + $clog2(MAX_DIM);
	localparam int PROD_W = SCORE_W + PROJ_W;
	localparam int OUT_W = 64;

	typedef logic signed [ELEM_W-1:0] elem_t;
	typedef logic signed [PROJ_W-1:0] proj_t;
	typedef logic signed [SCORE_W-1:0] score_t;
	typedef logic signed [PROD_W-1:0] prod_t;
	typedef logic signed [OUT_W-1:0] out_t;

endpackage

// ==== verilog/attn_output.sv ====
// Output pipeline
// Stage 1 registers the DIM products S[row][k]*V[k][col],
// stage 2 registers their sum; out_data is zero outside out_valid

`timescale 1ns/1ps

module attn_output #(
	parameter int DIM = attn_num_pkg::MAX_DIM
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 out_issue,
	input  attn_ctrl_pkg::idx_t  row,
	input  attn_ctrl_pkg::idx_t  col,
	input  attn_num_pkg::score_t s_mat [DIM][DIM],
	input  attn_num_pkg::proj_t  v_mat [DIM][DIM],
	output logic                 out_valid,
	output attn_num_pkg::out_t   out_data
);
	import attn_ctrl_pkg::*;
	import attn_num_pkg::*;

	prod_t prod_q [DIM];
	out_t sum;
	out_t sum_q;
	logic [OUT_LAT-1:0] valid_pipe;

	always_ff @(posedge clk) begin
		if (out_issue) begin
			for (int k = 0; k < DIM; k++)
				prod_q[k] <= s_mat[row][k] * v_mat[k][col];
		end
	end

	// Zero rows of V cover any T, so all DIM terms are summed
	always_comb begin
		sum = '0;
		for (int k = 0; k < DIM; k++)
			sum = sum + prod_q[k];
	end

	always_ff @(posedge clk) begin
		if (valid_pipe[0])
			sum_q <= sum;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			valid_pipe <= '0;
		else
			valid_pipe <= {valid_pipe[OUT_LAT-2:0], out_issue};
	end

	assign out_valid = valid_pipe[OUT_LAT-1];
	assign out_data = out_valid ? sum_q : '0;

endmodule

// ==== verilog/attn_projection.sv ====
// Projection array
// DIM row-parallel MACs build Q, K and V one column at a time,
// one step of the inner product per cycle

`timescale 1ns/1ps

module attn_projection #(
	parameter int DIM = attn_num_pkg::MAX_DIM
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     proj_en,
	input  attn_ctrl_pkg::mat_sel_t  mat_sel,
	input  attn_ctrl_pkg::idx_t      step,
	input  attn_ctrl_pkg::idx_t      col,
	input  attn_num_pkg::elem_t      x_mat [DIM][DIM],
	input  attn_num_pkg::elem_t      wq_mat [DIM][DIM],
	input  attn_num_pkg::elem_t      wk_mat [DIM][DIM],
	input  attn_num_pkg::elem_t      wv_mat [DIM][DIM],
	output attn_num_pkg::proj_t      q_mat [DIM][DIM],
	output attn_num_pkg::proj_t      k_mat [DIM][DIM],
	output attn_num_pkg::proj_t      v_mat [DIM][DIM]
);
	import attn_ctrl_pkg::*;
	import attn_num_pkg::*;

	localparam idx_t LAST = idx_t'(DIM - 1);

	elem_t w_elem;
	proj_t acc [DIM];
	proj_t sum [DIM];

	// One weight element is shared by every row
	always_comb begin
		case (mat_sel)
			MAT_K: w_elem = wk_mat[step][col];
			MAT_V: w_elem = wv_mat[step][col];
			default: w_elem = wq_mat[step][col];
		endcase
		for (int r = 0; r < DIM; r++) begin
			sum[r] = x_mat[r][step] * w_elem;
			if (step != '0)
				sum[r] = sum[r] + acc[r];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int r = 0; r < DIM; r++)
				acc[r] <= '0;
		end else if (proj_en) begin
			for (int r = 0; r < DIM; r++)
				acc[r] <= sum[r];
		end
	end

	always_ff @(posedge clk) begin
		if (proj_en && step == LAST) begin
			for (int r = 0; r < DIM; r++) begin
				case (mat_sel)
					MAT_Q: q_mat[r][col] <= sum[r];
					MAT_K: k_mat[r][col] <= sum[r];
					default: v_mat[r][col] <= sum[r];
				endcase
			end
		end
	end

endmodule

// ==== verilog/attn_score.sv ====
// Score array
// DIM column-parallel MACs build one row of S = Q*K^T per DIM cycles,
// then clamp negatives to zero and divide by 3

`timescale 1ns/1ps

module attn_score #(
	parameter int DIM = attn_num_pkg::MAX_DIM
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 score_en,
	input  attn_ctrl_pkg::idx_t  step,
	input  attn_ctrl_pkg::idx_t  row,
	input  attn_num_pkg::proj_t  q_mat [DIM][DIM],
	input  attn_num_pkg::proj_t  k_mat [DIM][DIM],
	output attn_num_pkg::score_t s_mat [DIM][DIM]
);
	import attn_ctrl_pkg::*;
	import attn_num_pkg::*;

	localparam idx_t LAST = idx_t'(DIM - 1);

	score_t acc [DIM];
	score_t sum [DIM];

	always_comb begin
		for (int c = 0; c < DIM; c++) begin
			sum[c] = q_mat[row][step] * k_mat[c][step];
			if (step != '0)
				sum[c] = sum[c] + acc[c];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int c = 0; c < DIM; c++)
				acc[c] <= '0;
		end else if (score_en) begin
			for (int c = 0; c < DIM; c++)
				acc[c] <= sum[c];
		end
	end

	always_ff @(posedge clk) begin
		if (score_en && step == LAST) begin
			for (int c = 0; c < DIM; c++)
				s_mat[row][c] <= (sum[c] < 0) ? score_t'(0) : score_t'(sum[c] / 3);
		end
	end

endmodule

// ==== verilog/attn_top.sv ====
// Attention engine top level
// Loader, phase controller, projection and score arrays and the
// output pipeline, all sized by DIM

`timescale 1ns/1ps

module attn_top #(
	parameter int DIM = attn_num_pkg::MAX_DIM
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_valid,
	input  attn_ctrl_pkg::rows_t T,
	input  attn_num_pkg::elem_t  in_data,
	input  attn_num_pkg::elem_t  w_q,
	input  attn_num_pkg::elem_t  w_k,
	input  attn_num_pkg::elem_t  w_v,
	output logic                 out_valid,
	output attn_num_pkg::out_t   out_data
);
	import attn_num_pkg::*;
	import attn_ctrl_pkg::*;

	elem_t x_mat [DIM][DIM];
	elem_t wq_mat [DIM][DIM];
	elem_t wk_mat [DIM][DIM];
	elem_t wv_mat [DIM][DIM];
	proj_t q_mat [DIM][DIM];
	proj_t k_mat [DIM][DIM];
	proj_t v_mat [DIM][DIM];
	score_t s_mat [DIM][DIM];

	rows_t rows;
	logic load_done;
	logic accept;
	logic proj_en;
	logic score_en;
	logic out_issue;
	mat_sel_t mat_sel;
	idx_t step;
	idx_t col;
	idx_t row;

	attn_loader #(.DIM(DIM)) u_loader (
		.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .t_in(T),
		.in_data(in_data), .w_q(w_q), .w_k(w_k), .w_v(w_v), .accept(accept),
		.x_mat(x_mat), .wq_mat(wq_mat), .wk_mat(wk_mat), .wv_mat(wv_mat),
		.rows(rows), .load_done(load_done)
	);

	attn_ctrl #(.DIM(DIM)) u_ctrl (
		.clk(clk), .rst_n(rst_n), .load_done(load_done), .rows(rows),
		.accept(accept), .proj_en(proj_en), .mat_sel(mat_sel),
		.score_en(score_en), .out_issue(out_issue),
		.step(step), .col(col), .row(row)
	);

	attn_projection #(.DIM(DIM)) u_projection (
		.clk(clk), .rst_n(rst_n), .proj_en(proj_en), .mat_sel(mat_sel),
		.step(step), .col(col), .x_mat(x_mat), .wq_mat(wq_mat),
		.wk_mat(wk_mat), .wv_mat(wv_mat), .q_mat(q_mat), .k_mat(k_mat), .v_mat(v_mat)
	);

	attn_score #(.DIM(DIM)) u_score (
		.clk(clk), .rst_n(rst_n), .score_en(score_en), .step(step), .row(row),
		.q_mat(q_mat), .k_mat(k_mat), .s_mat(s_mat)
	);

	attn_output #(.DIM(DIM)) u_output (
		.clk(clk), .rst_n(rst_n), .out_issue(out_issue), .row(row), .col(col),
		.s_mat(s_mat), .v_mat(v_mat), .out_valid(out_valid), .out_data(out_data)
	);

endmodule
